//--- in_switch.f
rtl/in_switch_pkg.sv
rtl/buff_alloc.sv
rtl/port_ctrl.sv
rtl/buff_steer.sv
rtl/in_switch.sv
verif/tb_in_switch.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the in_switch testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f in_switch.f --top-module tb_in_switch -o tb_in_switch
./obj_dir/tb_in_switch > sim.log
cat sim.log
if grep -q "SIMULATION PASSED" sim.log; then
	echo "result: pass"
else
	echo "result: fail"
	exit 1
fi

//--- verif/tb_in_switch.sv
// input switch testbench
`timescale 1ns/10ps

module tb_in_switch;
	import in_switch_pkg::*;

	localparam int MAX_PKTS = 512;
	localparam int TIMEOUT = 2000;

	logic clk;
	logic reset;
	flit_t in_flit [NUM_PORTS];
	port_vec_t in_req;
	port_vec_t in_bypass;
	port_vec_t in_ack;
	flit_t pb_flit [NUM_BUFFS];
	buff_vec_t pb_req;
	buff_vec_t pb_ack;
	buff_vec_t pb_empty;

	// per packet records by packet id
	int pkt_len [MAX_PKTS];
	int pkt_byp [MAX_PKTS];
	int pkt_buff [MAX_PKTS];
	int pkt_done [MAX_PKTS];
	int pkt_ack_cyc [MAX_PKTS];
	int pkt_rel_cyc [MAX_PKTS];
	// buffer model state
	flit_t rx [NUM_BUFFS][$];
	int bstate [NUM_BUFFS];
	int cnt [NUM_BUFFS];
	int ack_cyc [NUM_BUFFS];
	buff_vec_t req_prev;
	buff_vec_t slow_mask;
	int next_pid;
	int cyc;
	int errors;
	int err_mark;
	int pid;
	string test_name;

	in_switch uut (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// buffers a packet may land in for its bypass bit
	function automatic buff_vec_t expected_pool(input int byp);
		if (byp != 0) begin
			return 6'b110000;
		end else begin
			return 6'b001111;
		end
	endfunction

	// flit contents carry packet id and flit index
	function automatic flit_t make_flit(input int id, input int idx);
		flit_t f;
		f.data = {16'(id), 16'(idx), 32'(id) * 32'h9e3779b1 + 32'(idx)};
		f.route = 24'(id * 7 + 1);
		f.wr = 1'b1;
		return f;
	endfunction

	task automatic report_test();
		$display("test %s finished with %0d errors", test_name, errors - err_mark);
		err_mark = errors;
	endtask

	// compare what a closed link on buffer b received with what was sent
	task automatic check_packet(input int b);
		int id;
		buff_vec_t pool;
		id = (rx[b].size() > 0) ? int'(rx[b][0].data[63:48]) : MAX_PKTS;
		if (id >= next_pid) begin
			$display("buffer %0d closed a link without a valid packet in it", b);
			errors++;
		end else begin
			pool = expected_pool(pkt_byp[id]);
			if (!pool[b] || rx[b].size() != pkt_len[id]) begin
				$display("[FAIL] %s pkt%0d expected pool %b len %0d actual buffer %0d len %0d",
					test_name, id, pool, pkt_len[id], b, rx[b].size());
				errors++;
			end
			for (int i = 0; i < rx[b].size() && i < pkt_len[id]; i++) begin
				if (rx[b][i] != make_flit(id, i)) begin
					$display("[FAIL] %s pkt%0d flit%0d expected %h actual %h",
						test_name, id, i, make_flit(id, i), rx[b][i]);
					errors++;
				end
			end
			pkt_buff[id] = b;
			pkt_done[id]++;
			pkt_ack_cyc[id] = ack_cyc[b];
			pkt_rel_cyc[id] = cyc;
		end
		rx[b].delete();
	endtask

	task automatic wait_ack(input int p, input logic level, input int id);
		int waited;
		waited = 0;
		while (in_ack[p] != level) begin
			@(posedge clk);
			waited++;
			if (waited > TIMEOUT) begin
				$display("port %0d timed out waiting for in_ack %0b on packet %0d",
					p, level, id);
				$display("SIMULATION FAILED");
				$finish;
			end
		end
	endtask

	task automatic send_packet(input int p, input int byp, input int len, output int id);
		int idx;
		int rise;
		id = next_pid;
		next_pid++;
		pkt_len[id] = len;
		pkt_byp[id] = byp;
		pkt_buff[id] = -1;
		pkt_done[id] = 0;
		in_req[p] <= 1'b1;
		in_bypass[p] <= byp[0];
		wait_ack(p, 1'b1, id);
		rise = cyc;
		idx = 0;
		// idle cycles mixed in between the valid flits
		while (idx < len) begin
			if ($urandom_range(3) == 0) begin
				in_flit[p].wr <= 1'b0;
			end else begin
				in_flit[p] <= make_flit(id, idx);
				idx++;
			end
			@(posedge clk);
		end
		in_flit[p].wr <= 1'b0;
		in_req[p] <= 1'b0;
		wait_ack(p, 1'b0, id);
		if (pkt_done[id] != 1) begin
			$display("[FAIL] %s pkt%0d links expected 1 actual %0d",
				test_name, id, pkt_done[id]);
			errors++;
		end else if (rise <= pkt_ack_cyc[id] || cyc <= pkt_rel_cyc[id]) begin
			$display("packet %0d on port %0d moved in_ack ahead of its buffer's pb_ack", id, p);
			errors++;
		end
	endtask

	task automatic port_burst(input int p, input int n);
		int id;
		repeat (n) begin
			send_packet(p, $urandom_range(1), $urandom_range(6, 1), id);
		end
	endtask

	task automatic run_burst(input string name, input int n, input buff_vec_t slow);
		test_name = name;
		slow_mask = slow;
		fork
			port_burst(0, n);
			port_burst(1, n);
			port_burst(2, n);
			port_burst(3, n);
		join
		slow_mask = '0;
		report_test();
	endtask

	// buffer model states 0 empty, 1 ack delay, 2 linked, 3 release delay, 4 draining
	always @(posedge clk) begin
		if (!reset) begin
			for (int b = 0; b < NUM_BUFFS; b++) begin
				if (pb_flit[b].wr) begin
					rx[b].push_back(pb_flit[b]);
				end
				if (pb_req[b] && !req_prev[b] && bstate[b] != 0) begin
					$display("buffer %0d got a new pb_req before it was free again", b);
					errors++;
				end
				req_prev[b] = pb_req[b];
				if (bstate[b] == 0 && pb_req[b]) begin
					cnt[b] = slow_mask[b] ? 40 : $urandom_range(5);
					bstate[b] = 1;
				end else if (bstate[b] == 1 && cnt[b] > 0) begin
					cnt[b]--;
				end else if (bstate[b] == 1) begin
					pb_ack[b] <= 1'b1;
					pb_empty[b] <= 1'b0;
					ack_cyc[b] = cyc;
					bstate[b] = 2;
				end else if (bstate[b] == 2 && !pb_req[b]) begin
					cnt[b] = $urandom_range(3);
					bstate[b] = 3;
				end else if (bstate[b] == 3 && cnt[b] > 0) begin
					cnt[b]--;
				end else if (bstate[b] == 3) begin
					pb_ack[b] <= 1'b0;
					check_packet(b);
					cnt[b] = $urandom_range(4, 1);
					bstate[b] = 4;
				end else if (bstate[b] == 4) begin
					cnt[b]--;
					if (cnt[b] == 0) begin
						pb_empty[b] <= 1'b1;
						bstate[b] = 0;
					end
				end
			end
		end
	end

	initial begin
		void'($urandom(21570));
		clk = 1'b0;
		reset = 1'b1;
		in_req = '0;
		in_bypass = '0;
		pb_ack = '0;
		pb_empty = '1;
		req_prev = '0;
		slow_mask = '0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			in_flit[p] = '0;
		end
		next_pid = 0;
		cyc = 0;
		errors = 0;
		err_mark = 0;
		test_name = "single_packet";
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		repeat (3) @(posedge clk);
		if (in_ack != '0 || pb_req != '0) begin
			$display("[FAIL] %s reset outputs expected 0 actual in_ack %b pb_req %b",
				test_name, in_ack, pb_req);
			errors++;
		end
		send_packet(1, 0, 3, pid);
		if (pkt_buff[pid] != 0) begin
			$display("[FAIL] %s first normal buffer expected 0 actual %0d",
				test_name, pkt_buff[pid]);
			errors++;
		end
		send_packet(1, 1, 3, pid);
		if (pkt_buff[pid] != 4) begin
			$display("[FAIL] %s first bypass buffer expected 4 actual %0d",
				test_name, pkt_buff[pid]);
			errors++;
		end
		report_test();
		test_name = "pool_and_order";
		for (int k = 0; k < 12; k++) begin
			send_packet(k % 4, $urandom_range(1), $urandom_range(6, 1), pid);
		end
		report_test();
		run_burst("all_ports", 4, '0);
		// buffers 0 and 4 hold back pb_ack
		run_burst("back_pressure", 4, 6'b010001);
		run_burst("random_200", 50, '0);
		$display("%0d packets sent, %0d errors", next_pid, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- rtl/in_switch.sv
// mesh router input switch top
`timescale 1ns/10ps

module in_switch (
	input logic clk,
	input logic reset,
	input in_switch_pkg::flit_t in_flit [in_switch_pkg::NUM_PORTS],
	input in_switch_pkg::port_vec_t in_req,
	input in_switch_pkg::port_vec_t in_bypass,
	output in_switch_pkg::port_vec_t in_ack,
	output in_switch_pkg::flit_t pb_flit [in_switch_pkg::NUM_BUFFS],
	output in_switch_pkg::buff_vec_t pb_req,
	input in_switch_pkg::buff_vec_t pb_ack,
	input in_switch_pkg::buff_vec_t pb_empty
);
	import in_switch_pkg::*;

	port_vec_t in_req_q;
	buff_vec_t pb_ack_q;
	buff_vec_t pb_empty_q;

	port_vec_t norm_req;
	port_vec_t byp_req;
	port_vec_t norm_grant;
	port_vec_t byp_grant;
	buff_id_t norm_buff;
	buff_id_t byp_buff;

	port_vec_t active;
	buff_id_t port_buff [NUM_PORTS];
	buff_vec_t port_pb_req [NUM_PORTS];

	// all handshake inputs are sampled once before use
	always_ff @(posedge clk) begin
		if (reset) begin
			in_req_q <= '0;
			pb_ack_q <= '0;
			pb_empty_q <= '0;
		end else begin
			in_req_q <= in_req;
			pb_ack_q <= pb_ack;
			pb_empty_q <= pb_empty;
		end
	end

	buff_alloc #(
		.POOL_BASE(NORM_BASE),
		.POOL_SIZE(NORM_SIZE)
	) u_norm_alloc (
		.clk(clk),
		.reset(reset),
		.alloc_req(norm_req),
		.pb_empty_q(pb_empty_q),
		.pb_req(pb_req),
		.grant(norm_grant),
		.buff(norm_buff)
	);

	buff_alloc #(
		.POOL_BASE(BYP_BASE),
		.POOL_SIZE(BYP_SIZE)
	) u_byp_alloc (
		.clk(clk),
		.reset(reset),
		.alloc_req(byp_req),
		.pb_empty_q(pb_empty_q),
		.pb_req(pb_req),
		.grant(byp_grant),
		.buff(byp_buff)
	);

	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
		port_ctrl u_port_ctrl (
			.clk(clk),
			.reset(reset),
			.req_q(in_req_q[i]),
			.bypass(in_bypass[i]),
			.norm_req(norm_req[i]),
			.byp_req(byp_req[i]),
			.norm_grant(norm_grant[i]),
			.byp_grant(byp_grant[i]),
			.norm_buff(norm_buff),
			.byp_buff(byp_buff),
			.pb_ack_q(pb_ack_q),
			.buff(port_buff[i]),
			.pb_req(port_pb_req[i]),
			.active(active[i]),
			.ack(in_ack[i])
		);
	end

	buff_steer u_steer (
		.clk(clk),
		.reset(reset),
		.in_flit(in_flit),
		.active(active),
		.port_buff(port_buff),
		.port_pb_req(port_pb_req),
		.pb_flit(pb_flit),
		.pb_req(pb_req)
	);

endmodule

//--- rtl/buff_steer.sv
// flit steering into packet buffers
`timescale 1ns/10ps

module buff_steer (
	input logic clk,
	input logic reset,
	input in_switch_pkg::flit_t in_flit [in_switch_pkg::NUM_PORTS],
	input in_switch_pkg::port_vec_t active,
	input in_switch_pkg::buff_id_t port_buff [in_switch_pkg::NUM_PORTS],
	input in_switch_pkg::buff_vec_t port_pb_req [in_switch_pkg::NUM_PORTS],
	output in_switch_pkg::flit_t pb_flit [in_switch_pkg::NUM_BUFFS],
	output in_switch_pkg::buff_vec_t pb_req
);
	import in_switch_pkg::*;

	// each port's request is one-hot or zero, owners never overlap
	always_comb begin
		pb_req = '0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			pb_req = pb_req | port_pb_req[p];
		end
	end

	always_ff @(posedge clk) begin
		// buffers nobody writes this cycle see no valid flit
		for (int b = 0; b < NUM_BUFFS; b++) begin
			pb_flit[b].wr <= 1'b0;
		end
		if (!reset) begin
			for (int b = 0; b < NUM_BUFFS; b++) begin
				for (int p = 0; p < NUM_PORTS; p++) begin
					if (active[p] && port_buff[p] == buff_id_t'(b)) begin
						pb_flit[b] <= in_flit[p];
					end
				end
			end
		end
	end

endmodule

//--- rtl/port_ctrl.sv
// input port handshake controller
`timescale 1ns/10ps

module port_ctrl (
	input logic clk,
	input logic reset,
	input logic req_q,
	input logic bypass,
	output logic norm_req,
	output logic byp_req,
	input logic norm_grant,
	input logic byp_grant,
	input in_switch_pkg::buff_id_t norm_buff,
	input in_switch_pkg::buff_id_t byp_buff,
	input in_switch_pkg::buff_vec_t pb_ack_q,
	output in_switch_pkg::buff_id_t buff,
	output in_switch_pkg::buff_vec_t pb_req,
	output logic active,
	output logic ack
);
	import in_switch_pkg::*;

	port_state_t state;
	logic granted;
	buff_id_t grant_buff;
	logic buff_ack;

	// bypass picks the pool, held steady by the sender
	assign norm_req = (state == BUFF_LOOKUP) && !bypass;
	assign byp_req = (state == BUFF_LOOKUP) && bypass;

	assign granted = bypass ? byp_grant : norm_grant;
	assign grant_buff = bypass ? byp_buff : norm_buff;

	// sampled ack of the buffer this port owns
	assign buff_ack = pb_ack_q[buff];

	// flits pass from the first acked cycle until the request drops
	assign active = (state == TX) || ((state == BUFF_REQ) && buff_ack);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			buff <= '0;
			pb_req <= '0;
			ack <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (req_q) begin
						state <= BUFF_LOOKUP;
					end
				end
				BUFF_LOOKUP: begin
					if (granted) begin
						buff <= grant_buff;
						pb_req <= buff_vec_t'(1) << grant_buff;
						state <= BUFF_REQ;
					end
				end
				BUFF_REQ: begin
					// a slow buffer only stalls this port
					if (buff_ack) begin
						ack <= 1'b1;
						state <= TX;
					end
				end
				TX: begin
					if (!req_q) begin
						pb_req <= '0;
						state <= CANCEL;
					end
				end
				CANCEL: begin
					// ack to the sender falls only after the buffer lets go
					if (!buff_ack) begin
						ack <= 1'b0;
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

//--- rtl/buff_alloc.sv
// packet buffer pool allocator
`timescale 1ns/10ps

module buff_alloc #(
	parameter int POOL_BASE = in_switch_pkg::NORM_BASE,
	parameter int POOL_SIZE = in_switch_pkg::NORM_SIZE
) (
	input logic clk,
	input logic reset,
	input in_switch_pkg::port_vec_t alloc_req,
	input in_switch_pkg::buff_vec_t pb_empty_q,
	input in_switch_pkg::buff_vec_t pb_req,
	output in_switch_pkg::port_vec_t grant,
	output in_switch_pkg::buff_id_t buff
);
	import in_switch_pkg::*;

	alloc_state_t state;
	port_id_t ptr;
	buff_vec_t free_buffs;
	logic found;
	buff_id_t sel;

	// a buffer is free only if it is empty and nobody holds a request on it
	assign free_buffs = pb_empty_q & ~pb_req;

	// lowest free buffer inside this pool's slice
	always_comb begin
		found = 1'b0;
		sel = buff_id_t'(POOL_BASE);
		for (int i = POOL_SIZE - 1; i >= 0; i--) begin
			if (free_buffs[POOL_BASE + i]) begin
				found = 1'b1;
				sel = buff_id_t'(POOL_BASE + i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= LOOKUP;
			ptr <= '0;
			grant <= '0;
		end else begin
			// grant is a single-cycle pulse
			grant <= '0;
			case (state)
				LOOKUP: begin
					if (found) begin
						state <= GRANT;
					end
				end
				GRANT: begin
					// one port per cycle, pointer moves on either way
					ptr <= ptr + 1'b1;
					if (alloc_req[ptr]) begin
						grant[ptr] <= 1'b1;
						state <= WAIT1;
					end
				end
				// two idle cycles so the new pb_req reaches free_buffs
				WAIT1: begin
					state <= WAIT2;
				end
				WAIT2: begin
					state <= LOOKUP;
				end
				default: begin
					state <= LOOKUP;
				end
			endcase
		end
	end

	// buffer number held from GRANT until the next LOOKUP
	always_ff @(posedge clk) begin
		if (state == LOOKUP && found) begin
			buff <= sel;
		end
	end

endmodule

//--- rtl/in_switch_pkg.sv
// input switch shared types
package in_switch_pkg;

	// port numbering: 0 up, 1 left, 2 down, 3 right
	localparam int NUM_PORTS = 4;
	localparam int NUM_BUFFS = 6;

	// normal pool
	localparam int NORM_BASE = 0;
	localparam int NORM_SIZE = 4;

	// bypass pool sits right above the normal one
	localparam int BYP_BASE = 4;
	localparam int BYP_SIZE = 2;

	typedef logic [1:0] port_id_t;
	typedef logic [2:0] buff_id_t;
	typedef logic [NUM_PORTS-1:0] port_vec_t;
	typedef logic [NUM_BUFFS-1:0] buff_vec_t;

	typedef logic [63:0] word_t;
	typedef logic [23:0] route_t;

	// one flit as it crosses the switch, 89 bits
	typedef struct packed {
		word_t data;
		route_t route;
		logic wr;
	} flit_t;

	typedef enum logic [1:0] {
		LOOKUP,
		GRANT,
		WAIT1,
		WAIT2
	} alloc_state_t;

	typedef enum logic [2:0] {
		IDLE,
		BUFF_LOOKUP,
		BUFF_REQ,
		TX,
		CANCEL
	} port_state_t;

endpackage
